// ==== Bender.yml ====
package:
  name: ro_cache

sources:
  - files:
      - verilog/ro_cache_pkg.sv
      - verilog/region_decode.sv
      - verilog/line_lookup.sv
      - verilog/refill_unit.sv
      - verilog/ro_cache.sv
  - target: test
    files:
      - bench/ro_cache_sva.sv
      - bench/ro_cache_tb.sv

// ==== bench/ro_cache_sva.sv ====
// ------------------------------
// Port-level protocol checks for the read-only cache
// Bound into every ro_cache instance
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module ro_cache_sva (
  input logic                  clk_i,
  input logic                  rst_i,
  input ro_cache_pkg::rd_rsp_t rsp_o,
  input logic                  rsp_valid_o,
  input logic                  rsp_ready_i,
  input ro_cache_pkg::addr_t   mem_req_addr_o,
  input logic                  mem_req_valid_o,
  input logic                  mem_req_ready_i,
  input logic                  flush_ready_o
);

  import ro_cache_pkg::*;

  int unsigned fail_count = 0;

  // All status outputs come out of reset low
  reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !rsp_valid_o && !mem_req_valid_o && !flush_ready_o)
    else begin
      fail_count++;
      $error("status outputs not low after reset");
    end

  // Response held under back-pressure
  rsp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
    else begin
      fail_count++;
      $error("response changed while rsp_ready_i was low");
    end

  mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o))
    else begin
      fail_count++;
      $error("memory request dropped before mem_req_ready_i");
    end

  // A refill in progress never overlaps a response
  mem_or_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_o |-> !rsp_valid_o)
    else begin
      fail_count++;
      $error("response raised while a memory read is issued");
    end

  flush_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_ready_o |=> !flush_ready_o)
    else begin
      fail_count++;
      $error("flush_ready_o longer than one cycle");
    end

endmodule

bind ro_cache ro_cache_sva i_sva (.*);

`default_nettype wire

// ==== bench/ro_cache_tb.sv ====
// ------------------------------
// Testbench for the read-only cache with a random-latency memory model
// Predicts hits from the range rules and a shadow of the line store
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module ro_cache_tb;

  import ro_cache_pkg::*;

  localparam int unsigned LINE_COUNT    = 16;
  localparam int unsigned NR_ADDR_RULES = 2;
  localparam int unsigned IDX_W         = $clog2(LINE_COUNT);
  localparam addr_t       MEM_KEY       = 32'h5a5a_c3c3;
  localparam addr_t       ERR_BOUND     = 32'h0000_3000;
  localparam int unsigned RAND_READS    = 40;
  localparam int unsigned NUM_READS     = 8 + 8 + 1 + RAND_READS + 2 + 2;
  localparam int unsigned WORST_READ    = 24;
  localparam int unsigned TIMEOUT_CYCLES =
    3 * (NUM_READS * WORST_READ + 4 + LINE_COUNT + 2);
  localparam addr_t PASS_ADDR [8] = '{32'h1000, 32'h1004, 32'h1040, 32'h2800,
                                      32'h3000, 32'h3010, 32'h0400, 32'h1008};
  localparam logic [7:0] PASS_LOCK = 8'b1000_0000;

  typedef struct packed {
    addr_t       addr;
    logic        exp_hit;
    logic        timed;
    logic        mem_seen;
    logic        valid_seen;
    logic [31:0] acc_cycle;
  } read_rec_t;

  logic                      clk_i = 1'b0;
  logic                      rst_i;
  logic                      enable_i;
  logic                      flush_valid_i;
  logic                      flush_ready_o;
  addr_t [NR_ADDR_RULES-1:0] start_addr_i;
  addr_t [NR_ADDR_RULES-1:0] end_addr_i;
  rd_req_t                   req_i;
  logic                      req_valid_i;
  logic                      req_ready_o;
  rd_rsp_t                   rsp_o;
  logic                      rsp_valid_o;
  logic                      rsp_ready_i;
  addr_t                     mem_req_addr_o;
  logic                      mem_req_valid_o;
  logic                      mem_req_ready_i;
  rd_rsp_t                   mem_rsp_i;
  logic                      mem_rsp_valid_i;

  integer                seed = 34;
  int unsigned           cycle_cnt = 0;
  read_rec_t             pend_q [$];
  logic [LINE_COUNT-1:0] sh_valid = '0;
  addr_t                 sh_addr [LINE_COUNT];
  logic                  flush_open = 1'b0;
  int unsigned           flush_start;
  int unsigned           flush_accepts;
  logic                  mem_busy = 1'b0;
  addr_t                 mem_addr;
  int unsigned           mem_wait;

  ro_cache #(
    .LINE_COUNT    ( LINE_COUNT    ),
    .NR_ADDR_RULES ( NR_ADDR_RULES )
  ) dut (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .enable_i        ( enable_i        ),
    .flush_valid_i   ( flush_valid_i   ),
    .flush_ready_o   ( flush_ready_o   ),
    .start_addr_i    ( start_addr_i    ),
    .end_addr_i      ( end_addr_i      ),
    .req_i           ( req_i           ),
    .req_valid_i     ( req_valid_i     ),
    .req_ready_o     ( req_ready_o     ),
    .rsp_o           ( rsp_o           ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i )
  );

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("error %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "stopping at first failure");
  endtask

  // Cacheable when some range matches and the read is neither locked nor disabled
  function automatic logic is_cacheable(input addr_t addr, input logic lock, input logic en);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < NR_ADDR_RULES; i++) begin
      if ((addr >= start_addr_i[i]) && (addr < end_addr_i[i])) begin
        hit = 1'b1;
      end
    end
    return hit && !lock && en;
  endfunction

  // ------------------------------
  // Memory model and random ready
  // ------------------------------
  always @(negedge clk_i) begin
    mem_rsp_valid_i = 1'b0;
    rsp_ready_i     = ($random(seed) & 3) != 0;
    mem_req_ready_i = ($random(seed) & 3) != 0;
    if (mem_busy) begin
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        mem_rsp_i.data  = mem_addr ^ MEM_KEY;
        mem_rsp_i.error = mem_addr >= ERR_BOUND;
        mem_rsp_valid_i = 1'b1;
        mem_busy        = 1'b0;
      end
    end else if (mem_req_valid_o && mem_req_ready_i) begin
      // Handshake happens on the coming edge
      mem_busy = 1'b1;
      mem_addr = mem_req_addr_o;
      mem_wait = 1 + ($random(seed) & 3);
    end
  end

  // ------------------------------
  // Expected-value tracking
  // ------------------------------
  always @(posedge clk_i) begin
    read_rec_t        rec;
    logic             cacheable;
    logic [IDX_W-1:0] idx;
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end else if (!rst_i) begin
      assert (dut.i_sva.fail_count == 0)
        else report_failure("bound checker assertion failed");
      if (flush_valid_i && !flush_open) begin
        flush_open    = 1'b1;
        flush_start   = cycle_cnt;
        flush_accepts = 0;
        sh_valid      = '0;
      end
      if (flush_valid_i) begin
        assert (!rsp_valid_o && !mem_req_valid_o)
          else report_failure("lookup active while a flush runs");
        if (req_valid_i && req_ready_o) begin
          flush_accepts++;
        end
        assert (flush_accepts <= 1)
          else report_failure("request passed decode during a flush");
      end
      if (flush_open && flush_ready_o) begin
        assert (cycle_cnt - flush_start == LINE_COUNT + 1)
          else report_failure("flush length wrong");
        flush_open = 1'b0;
      end
      // Front of the queue is the read held in lookup
      if (mem_req_valid_o && mem_req_ready_i) begin
        assert (pend_q.size() != 0)
          else report_failure("memory request without a pending read");
        rec = pend_q[0];
        assert (!rec.exp_hit)
          else report_failure($sformatf("memory request for cached addr %h", rec.addr));
        assert (mem_req_addr_o == rec.addr)
          else report_failure($sformatf("mem addr %h, expected %h", mem_req_addr_o, rec.addr));
        rec.mem_seen = 1'b1;
        pend_q[0]    = rec;
      end
      if (rsp_valid_o && (pend_q.size() != 0)) begin
        rec = pend_q[0];
        if (!rec.valid_seen && rec.timed && rec.exp_hit) begin
          assert (cycle_cnt - rec.acc_cycle == 2)
            else report_failure($sformatf("hit on %h not 2 cycles after request", rec.addr));
        end
        rec.valid_seen = 1'b1;
        pend_q[0]      = rec;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        assert (pend_q.size() != 0)
          else report_failure("response without a pending read");
        rec = pend_q.pop_front();
        assert (rsp_o.data == (rec.addr ^ MEM_KEY))
          else report_failure($sformatf("addr %h data %h, expected %h",
                                        rec.addr, rsp_o.data, rec.addr ^ MEM_KEY));
        assert (rsp_o.error == (rec.addr >= ERR_BOUND))
          else report_failure($sformatf("addr %h error bit %b", rec.addr, rsp_o.error));
        assert (rec.mem_seen != rec.exp_hit)
          else report_failure($sformatf("addr %h memory traffic does not match hit %b",
                                        rec.addr, rec.exp_hit));
      end
      if (req_valid_i && req_ready_o) begin
        cacheable     = is_cacheable(req_i.addr, req_i.lock, enable_i);
        idx           = req_i.addr[IDX_W+1:2];
        rec           = '0;
        rec.addr      = req_i.addr;
        rec.exp_hit   = cacheable && sh_valid[idx] && (sh_addr[idx] == req_i.addr);
        rec.timed     = (pend_q.size() == 0) && !flush_valid_i;
        rec.acc_cycle = cycle_cnt;
        // Only error-free cacheable misses fill a line
        if (cacheable && !rec.exp_hit && (req_i.addr < ERR_BOUND)) begin
          sh_valid[idx] = 1'b1;
          sh_addr[idx]  = req_i.addr;
        end
        pend_q.push_back(rec);
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic issue_read(input addr_t addr, input logic lock);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i.addr  = addr;
    req_i.lock  = lock;
    @(posedge clk_i);
    while (!req_ready_o) @(posedge clk_i);
  endtask

  task automatic wait_idle();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (pend_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic read_and_wait(input addr_t addr, input logic lock);
    issue_read(addr, lock);
    wait_idle();
  endtask

  initial begin
    logic [31:0] r;
    addr_t       base;
    rst_i           = 1'b1;
    enable_i        = 1'b1;
    flush_valid_i   = 1'b0;
    start_addr_i[0] = 32'h1000;
    end_addr_i[0]   = 32'h2000;
    start_addr_i[1] = 32'h2800;
    end_addr_i[1]   = 32'h3800;
    req_i           = '0;
    req_valid_i     = 1'b0;
    rsp_ready_i     = 1'b1;
    mem_req_ready_i = 1'b0;
    mem_rsp_i       = '0;
    mem_rsp_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Cold pass back to back and then single reads for hit timing
    for (int i = 0; i < 8; i++) begin
      issue_read(PASS_ADDR[i], PASS_LOCK[i]);
    end
    wait_idle();
    for (int i = 0; i < 8; i++) begin
      read_and_wait(PASS_ADDR[i], PASS_LOCK[i]);
    end

    // Disabled cache bypasses a cached line
    @(negedge clk_i);
    enable_i = 1'b0;
    read_and_wait(32'h1004, 1'b0);
    enable_i = 1'b1;

    for (int n = 0; n < RAND_READS; n++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    base = 32'h1000;
        2'd1:    base = 32'h2fc0;
        2'd2:    base = 32'h37c0;
        default: base = 32'h0400;
      endcase
      issue_read(base + {r[6:2], 2'b00}, r[11:9] == 3'd0);
    end
    wait_idle();

    // Flush with two reads queued behind it
    @(negedge clk_i);
    flush_valid_i = 1'b1;
    fork
      begin
        issue_read(32'h1004, 1'b0);
        issue_read(32'h2800, 1'b0);
      end
      begin
        @(posedge clk_i);
        while (!flush_ready_o) @(posedge clk_i);
        @(negedge clk_i);
        flush_valid_i = 1'b0;
      end
    join
    wait_idle();
    read_and_wait(32'h1004, 1'b0);
    read_and_wait(32'h2800, 1'b0);

    repeat (4) @(negedge clk_i);
    if (dut.i_sva.fail_count != 0) begin
      report_failure("bound checker assertion failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/ro_cache_pkg.sv
verilog/region_decode.sv
verilog/line_lookup.sv
verilog/refill_unit.sv
verilog/ro_cache.sv
bench/ro_cache_sva.sv
bench/ro_cache_tb.sv

// ==== verilog/line_lookup.sv ====
// ------------------------------
// Direct-mapped line store with hit check, flush walk and refill write
// Answers hits itself and hands misses and bypasses to the refill unit
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module line_lookup #(
  parameter int unsigned LINE_COUNT = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_valid_i,
  output logic                   flush_ready_o,
  input  ro_cache_pkg::dec_req_t dec_i,
  input  logic                   dec_valid_i,
  output logic                   dec_ready_o,
  output ro_cache_pkg::dec_req_t miss_o,
  output logic                   miss_valid_o,
  input  logic                   miss_ready_i,
  input  ro_cache_pkg::rd_rsp_t  refill_i,
  input  logic                   refill_valid_i,
  output ro_cache_pkg::rd_rsp_t  rsp_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i
);

  import ro_cache_pkg::*;

  localparam int unsigned IDX_W = $clog2(LINE_COUNT);
  localparam int unsigned TAG_W = ADDR_WIDTH - IDX_W - 2;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // Line store, indexed by word address
  logic [LINE_COUNT-1:0] valid_q;
  tag_t                  tag_q  [LINE_COUNT];
  data_t                 data_q [LINE_COUNT];

  lookup_state_e state_q;
  dec_req_t      req_q;
  rd_rsp_t       rsp_q;
  logic          miss_valid_q;
  logic          flush_ready_q;
  idx_t          flush_idx_q;

  idx_t  in_idx;
  tag_t  in_tag;
  logic  in_hit;
  logic  dec_fire;
  logic  flush_start;
  fill_t fill;
  idx_t  fill_idx;
  logic  fill_en;

  // ------------------------------
  // Hit check and fill
  // ------------------------------
  assign in_idx = dec_i.addr[IDX_W+1:2];
  assign in_tag = dec_i.addr[ADDR_WIDTH-1:IDX_W+2];
  assign in_hit = dec_i.cacheable && valid_q[in_idx] && (tag_q[in_idx] == in_tag);

  // Flush wins over a waiting request
  assign flush_start = (state_q == IDLE) && flush_valid_i && !flush_ready_q;
  assign dec_ready_o = (state_q == IDLE) && !flush_valid_i;
  assign dec_fire    = dec_valid_i && dec_ready_o;

  // Only error-free cacheable refills land in the store
  assign fill.addr = req_q.addr;
  assign fill.data = refill_i.data;
  assign fill_idx  = fill.addr[IDX_W+1:2];
  assign fill_en   = (state_q == WAIT_REFILL) && refill_valid_i &&
                     req_q.cacheable && !refill_i.error;

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= IDLE;
      valid_q       <= '0;
      miss_valid_q  <= 1'b0;
      flush_ready_q <= 1'b0;
      flush_idx_q   <= '0;
    end else begin
      flush_ready_q <= 1'b0;
      if (miss_valid_q && miss_ready_i) begin
        miss_valid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (flush_start) begin
            state_q     <= FLUSH;
            flush_idx_q <= '0;
          end else if (dec_fire) begin
            if (in_hit) begin
              state_q <= RESPOND;
            end else begin
              state_q      <= WAIT_REFILL;
              miss_valid_q <= 1'b1;
            end
          end
        end
        FLUSH: begin
          // One line per cycle
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == idx_t'(LINE_COUNT - 1)) begin
            flush_ready_q <= 1'b1;
            state_q       <= IDLE;
          end
        end
        WAIT_REFILL: begin
          if (fill_en) begin
            valid_q[fill_idx] <= 1'b1;
          end
          if (refill_valid_i) begin
            state_q <= RESPOND;
          end
        end
        RESPOND: begin
          if (rsp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // Payload and store writes
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (dec_fire) begin
      req_q      <= dec_i;
      rsp_q.data <= data_q[in_idx];
      rsp_q.error <= 1'b0;
    end else if ((state_q == WAIT_REFILL) && refill_valid_i) begin
      rsp_q <= refill_i;
    end
    if (fill_en) begin
      tag_q[fill_idx]  <= fill.addr[ADDR_WIDTH-1:IDX_W+2];
      data_q[fill_idx] <= fill.data;
    end
  end

  assign miss_o        = req_q;
  assign miss_valid_o  = miss_valid_q;
  assign rsp_o         = rsp_q;
  assign rsp_valid_o   = (state_q == RESPOND);
  assign flush_ready_o = flush_ready_q;

endmodule

`default_nettype wire

// ==== verilog/refill_unit.sv ====
// ------------------------------
// Issues one memory read per miss or bypass and returns the word
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module refill_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  ro_cache_pkg::dec_req_t miss_i,
  input  logic                   miss_valid_i,
  output logic                   miss_ready_o,
  output ro_cache_pkg::addr_t    mem_req_addr_o,
  output logic                   mem_req_valid_o,
  input  logic                   mem_req_ready_i,
  input  ro_cache_pkg::rd_rsp_t  mem_rsp_i,
  input  logic                   mem_rsp_valid_i,
  output ro_cache_pkg::rd_rsp_t  refill_o,
  output logic                   refill_valid_o
);

  import ro_cache_pkg::*;

  logic    pending_q;
  logic    req_valid_q;
  logic    refill_valid_q;
  addr_t   addr_q;
  rd_rsp_t refill_q;

  logic    miss_fire;
  logic    rsp_fire;

  // Single outstanding read
  assign miss_ready_o = !pending_q;
  assign miss_fire    = miss_valid_i && miss_ready_o;

  // Response only counts once the address phase is done
  assign rsp_fire = mem_rsp_valid_i && pending_q && !req_valid_q;

  // ------------------------------
  // Request tracking
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q      <= 1'b0;
      req_valid_q    <= 1'b0;
      refill_valid_q <= 1'b0;
    end else begin
      refill_valid_q <= rsp_fire;
      if (miss_fire) begin
        pending_q   <= 1'b1;
        req_valid_q <= 1'b1;
      end else begin
        if (req_valid_q && mem_req_ready_i) begin
          req_valid_q <= 1'b0;
        end
        if (rsp_fire) begin
          pending_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_fire) begin
      addr_q <= miss_i.addr;
    end
    if (rsp_fire) begin
      refill_q <= mem_rsp_i;
    end
  end

  assign mem_req_addr_o  = addr_q;
  assign mem_req_valid_o = req_valid_q;
  assign refill_o        = refill_q;
  assign refill_valid_o  = refill_valid_q;

endmodule

`default_nettype wire

// ==== verilog/region_decode.sv ====
// ------------------------------
// Decode stage, registers a read and marks it cacheable or bypassed
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module region_decode #(
  parameter int unsigned NR_ADDR_RULES = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        enable_i,
  input  ro_cache_pkg::addr_t [NR_ADDR_RULES-1:0]     start_addr_i,
  input  ro_cache_pkg::addr_t [NR_ADDR_RULES-1:0]     end_addr_i,
  input  ro_cache_pkg::rd_req_t                       req_i,
  input  logic                                        req_valid_i,
  output logic                                        req_ready_o,
  output ro_cache_pkg::dec_req_t                      dec_o,
  output logic                                        dec_valid_o,
  input  logic                                        dec_ready_i
);

  import ro_cache_pkg::*;

  logic     in_range;
  logic     cacheable;
  logic     req_fire;
  logic     valid_q;
  dec_req_t dec_q;

  // ------------------------------
  // Address range match
  // ------------------------------
  always_comb begin
    in_range = 1'b0;
    for (int i = 0; i < NR_ADDR_RULES; i++) begin
      // End address is exclusive
      if ((req_i.addr >= start_addr_i[i]) && (req_i.addr < end_addr_i[i])) begin
        in_range = 1'b1;
      end
    end
  end

  // Locked reads and a disabled cache always go to memory
  assign cacheable = in_range && !req_i.lock && enable_i;

  // ------------------------------
  // One-entry output stage
  // ------------------------------
  assign req_ready_o = !valid_q || dec_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_fire) begin
      valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      dec_q.addr      <= req_i.addr;
      dec_q.cacheable <= cacheable;
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== verilog/ro_cache.sv ====
// ------------------------------
// Read-only cache top, chains decode, lookup and refill stages
// Set LINE_COUNT and NR_ADDR_RULES here
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module ro_cache #(
  parameter int unsigned LINE_COUNT    = 16,
  parameter int unsigned NR_ADDR_RULES = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    enable_i,
  input  logic                                    flush_valid_i,
  output logic                                    flush_ready_o,
  input  ro_cache_pkg::addr_t [NR_ADDR_RULES-1:0] start_addr_i,
  input  ro_cache_pkg::addr_t [NR_ADDR_RULES-1:0] end_addr_i,
  input  ro_cache_pkg::rd_req_t                   req_i,
  input  logic                                    req_valid_i,
  output logic                                    req_ready_o,
  output ro_cache_pkg::rd_rsp_t                   rsp_o,
  output logic                                    rsp_valid_o,
  input  logic                                    rsp_ready_i,
  output ro_cache_pkg::addr_t                     mem_req_addr_o,
  output logic                                    mem_req_valid_o,
  input  logic                                    mem_req_ready_i,
  input  ro_cache_pkg::rd_rsp_t                   mem_rsp_i,
  input  logic                                    mem_rsp_valid_i
);

  import ro_cache_pkg::*;

  dec_req_t dec;
  logic     dec_valid;
  logic     dec_ready;

  dec_req_t miss;
  logic     miss_valid;
  logic     miss_ready;

  rd_rsp_t  refill;
  logic     refill_valid;

  region_decode #(
    .NR_ADDR_RULES ( NR_ADDR_RULES )
  ) i_region_decode (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .enable_i     ( enable_i     ),
    .start_addr_i ( start_addr_i ),
    .end_addr_i   ( end_addr_i   ),
    .req_i        ( req_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .dec_o        ( dec          ),
    .dec_valid_o  ( dec_valid    ),
    .dec_ready_i  ( dec_ready    )
  );

  line_lookup #(
    .LINE_COUNT ( LINE_COUNT )
  ) i_line_lookup (
    .clk_i          ( clk_i         ),
    .rst_i          ( rst_i         ),
    .flush_valid_i  ( flush_valid_i ),
    .flush_ready_o  ( flush_ready_o ),
    .dec_i          ( dec           ),
    .dec_valid_i    ( dec_valid     ),
    .dec_ready_o    ( dec_ready     ),
    .miss_o         ( miss          ),
    .miss_valid_o   ( miss_valid    ),
    .miss_ready_i   ( miss_ready    ),
    .refill_i       ( refill        ),
    .refill_valid_i ( refill_valid  ),
    .rsp_o          ( rsp_o         ),
    .rsp_valid_o    ( rsp_valid_o   ),
    .rsp_ready_i    ( rsp_ready_i   )
  );

  refill_unit i_refill_unit (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .miss_i          ( miss            ),
    .miss_valid_i    ( miss_valid      ),
    .miss_ready_o    ( miss_ready      ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_i       ( mem_rsp_i       ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .refill_o        ( refill          ),
    .refill_valid_o  ( refill_valid    )
  );

endmodule

`default_nettype wire

// ==== verilog/ro_cache_pkg.sv ====
// ------------------------------
// Shared widths, payload structs and FSM state for the read-only cache
// Imported by every RTL module of the cache
// ------------------------------
`default_nettype none

package ro_cache_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Requester read, lock marks an atomic access
  typedef struct packed {
    addr_t addr;
    logic  lock;
  } rd_req_t;

  // Request after region decode
  typedef struct packed {
    addr_t addr;
    logic  cacheable;
  } dec_req_t;

  // Read data with bus error flag
  typedef struct packed {
    data_t data;
    logic  error;
  } rd_rsp_t;

  // One word written into the line store
  typedef struct packed {
    addr_t addr;
    data_t data;
  } fill_t;

  typedef enum logic [1:0] {
    IDLE,
    FLUSH,
    WAIT_REFILL,
    RESPOND
  } lookup_state_e;

endpackage

`default_nettype wire
